// ==== ibus.f ====
src/flash_pkg.sv
src/spi_cmd_if.sv
src/spi_tx.sv
src/flash_fetch_ctrl.sv
src/ibus.sv
tb/spi_flash_model.sv
tb/tb_ibus.sv

// ==== src/flash_fetch_ctrl.sv ====
`default_nettype none

module flash_fetch_ctrl (
    input wire                     wb_clk,
    input wire                     wb_rst,
    input wire [31:0]              wb_ibus_adr,
    input wire                     wb_ibus_cyc,
    output flash_pkg::flash_word_t wb_ibus_rdt,
    output logic                   wb_ibus_ack,
    spi_cmd_if.ctrl                cmd
);

    flash_pkg::seq_state_e  state;
    flash_pkg::spi_opcode_e code_q;
    logic                   tx_addr_q;
    logic                   no_read_q;

    // Request pulse used by the reset sequence
    logic seq_req;

    logic [9:0] wait_cnt;

    logic running;
    logic fetching;
    logic fetch_start;
    flash_pkg::flash_word_t rdata_swap;

    assign running     = (state == flash_pkg::st_running);
    assign fetch_start = running & wb_ibus_cyc & cmd.ready & !fetching;

    // Reset sequencer
    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            state     <= flash_pkg::st_reset;
            code_q    <= flash_pkg::spi_read;
            tx_addr_q <= 1'b1;
            no_read_q <= 1'b0;
            seq_req   <= 1'b0;
            wait_cnt  <= '0;
        end else begin
            case (state)
                flash_pkg::st_reset: begin
                    state     <= flash_pkg::st_reset_en_start;
                    code_q    <= flash_pkg::spi_reset_en;
                    tx_addr_q <= 1'b0;
                    no_read_q <= 1'b1;
                    seq_req   <= 1'b1;
                end
                flash_pkg::st_reset_en_start: begin
                    seq_req <= 1'b0;
                    state   <= flash_pkg::st_reset_en;
                end
                flash_pkg::st_reset_en: begin
                    if (cmd.ready) begin
                        state   <= flash_pkg::st_reset_req_start;
                        code_q  <= flash_pkg::spi_reset_req;
                        seq_req <= 1'b1;
                    end
                end
                flash_pkg::st_reset_req_start: begin
                    seq_req <= 1'b0;
                    state   <= flash_pkg::st_reset_req;
                end
                flash_pkg::st_reset_req: begin
                    // Set up for plain reads once both commands are sent
                    if (cmd.ready) begin
                        state     <= flash_pkg::st_waiting;
                        code_q    <= flash_pkg::spi_read;
                        tx_addr_q <= 1'b1;
                        no_read_q <= 1'b0;
                        wait_cnt  <= '0;
                    end
                end
                flash_pkg::st_waiting: begin
                    wait_cnt <= wait_cnt + 10'd1;
                    if (wait_cnt == 10'(flash_pkg::recover_cycles - 1)) begin
                        state <= flash_pkg::st_running;
                    end
                end
                flash_pkg::st_running: begin
                    state <= flash_pkg::st_running;
                end
                default: begin
                    state <= flash_pkg::st_reset;
                end
            endcase
        end
    end

    // One outstanding fetch at a time
    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            fetching <= 1'b0;
        end else if (fetch_start) begin
            fetching <= 1'b1;
        end else if (fetching && cmd.ready) begin
            fetching <= 1'b0;
        end
    end

    assign cmd.code    = code_q;
    assign cmd.tx_addr = tx_addr_q;
    assign cmd.no_read = no_read_q;
    assign cmd.req     = running ? fetch_start : seq_req;
    assign cmd.addr    = wb_ibus_adr[23:0] | flash_pkg::flash_code_base;

    // Flash delivers the lowest byte first
    assign rdata_swap = {cmd.rdata[7:0], cmd.rdata[15:8],
                         cmd.rdata[23:16], cmd.rdata[31:24]};

    assign wb_ibus_rdt = wb_ibus_cyc ? rdata_swap : '0;
    assign wb_ibus_ack = running & fetching & cmd.ready;

endmodule

`default_nettype wire

// ==== src/flash_pkg.sv ====
`default_nettype none

package flash_pkg;

    // Instruction word as seen on the Wishbone side
    typedef logic [31:0] flash_word_t;

    // Byte address into the SPI NOR array
    typedef logic [23:0] flash_addr_t;

    // Flash commands used by the bridge
    typedef enum logic [7:0] {
        spi_read      = 8'h03,
        spi_reset_en  = 8'h66,
        spi_reset_req = 8'h99
    } spi_opcode_e;

    // Reset sequencer and fetch states
    typedef enum logic [2:0] {
        st_reset,
        st_reset_en_start,
        st_reset_en,
        st_reset_req_start,
        st_reset_req,
        st_waiting,
        st_running
    } seq_state_e;

    // Code region starts at 1 MiB into the flash
    localparam flash_addr_t flash_code_base = 24'h10_0000;

    // Recovery time in wb_clk cycles after the software reset pair
    localparam int recover_cycles = 1024;

    // Field lengths of one SPI transaction
    localparam int cmd_bits  = 8;
    localparam int addr_bits = 24;
    localparam int data_bits = 32;

endpackage

`default_nettype wire

// ==== src/ibus.sv ====
`default_nettype none

module ibus (
    input wire         wb_clk,
    input wire         wb_rst,

    // Wishbone instruction port
    input wire  [31:0] wb_ibus_adr,
    input wire         wb_ibus_cyc,
    output logic [31:0] wb_ibus_rdt,
    output logic       wb_ibus_ack,

    // SPI flash pins
    output logic       spi_cs,
    output logic       spi_sck,
    output logic       spi_mosi,
    input wire         spi_miso
);

    // Command channel between controller and serial engine
    spi_cmd_if cmd_if ();

    flash_fetch_ctrl ctrl_i (
        .wb_clk      (wb_clk),
        .wb_rst      (wb_rst),
        .wb_ibus_adr (wb_ibus_adr),
        .wb_ibus_cyc (wb_ibus_cyc),
        .wb_ibus_rdt (wb_ibus_rdt),
        .wb_ibus_ack (wb_ibus_ack),
        .cmd         (cmd_if.ctrl)
    );

    spi_tx spi_i (
        .wb_clk   (wb_clk),
        .wb_rst   (wb_rst),
        .cmd      (cmd_if.engine),
        .spi_cs   (spi_cs),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

`default_nettype wire

// ==== src/spi_cmd_if.sv ====
`default_nettype none

interface spi_cmd_if;

    // Request side owned by the fetch controller
    flash_pkg::spi_opcode_e code;
    logic                   tx_addr;
    logic                   no_read;
    flash_pkg::flash_addr_t addr;
    logic                   req;

    // Result side owned by the serial engine
    flash_pkg::flash_word_t rdata;
    logic                   ready;

    modport ctrl (
        output code,
        output tx_addr,
        output no_read,
        output addr,
        output req,
        input  rdata,
        input  ready
    );

    modport engine (
        input  code,
        input  tx_addr,
        input  no_read,
        input  addr,
        input  req,
        output rdata,
        output ready
    );

endinterface

`default_nettype wire

// ==== src/spi_tx.sv ====
`default_nettype none

module spi_tx (
    input wire        wb_clk,
    input wire        wb_rst,
    spi_cmd_if.engine cmd,
    output logic      spi_cs,
    output logic      spi_sck,
    output logic      spi_mosi,
    input wire        spi_miso
);

    typedef enum logic [1:0] {
        eng_idle,
        eng_shift,
        eng_done
    } eng_state_e;

    eng_state_e state;

    // SCK is a plain toggle of wb_clk while shifting
    logic sck_q;

    // Bit index over the full frame of opcode, address and read data
    logic [5:0] bit_cnt;
    logic [5:0] bit_next;
    logic       last_bit;
    logic       in_read;

    // Flags latched with the request
    logic tx_addr_q;
    logic no_read_q;

    logic [flash_pkg::cmd_bits+flash_pkg::addr_bits+flash_pkg::data_bits-1:0] shreg;
    flash_pkg::flash_word_t rdata_q;

    // Next bit index skips the phases that are switched off
    always_comb begin
        in_read  = bit_cnt >= 6'(flash_pkg::cmd_bits + flash_pkg::addr_bits);
        last_bit = 1'b0;
        bit_next = bit_cnt + 6'd1;
        if (bit_cnt == 6'(flash_pkg::cmd_bits - 1) && !tx_addr_q) begin
            if (no_read_q) begin
                last_bit = 1'b1;
            end else begin
                bit_next = 6'(flash_pkg::cmd_bits + flash_pkg::addr_bits);
            end
        end else if (bit_cnt == 6'(flash_pkg::cmd_bits + flash_pkg::addr_bits - 1)) begin
            last_bit = no_read_q;
        end else if (bit_cnt == 6'(flash_pkg::cmd_bits + flash_pkg::addr_bits
                                   + flash_pkg::data_bits - 1)) begin
            last_bit = 1'b1;
        end
    end

    always_ff @(posedge wb_clk) begin
        if (wb_rst) begin
            state   <= eng_idle;
            sck_q   <= 1'b0;
            bit_cnt <= '0;
        end else begin
            case (state)
                eng_idle: begin
                    if (cmd.req) begin
                        state   <= eng_shift;
                        sck_q   <= 1'b0;
                        bit_cnt <= '0;
                    end
                end
                eng_shift: begin
                    sck_q <= !sck_q;
                    // A bit ends with the high half of SCK
                    if (sck_q) begin
                        if (last_bit) begin
                            state <= eng_done;
                        end else begin
                            bit_cnt <= bit_next;
                        end
                    end
                end
                // CS is high here for one cycle before ready returns
                eng_done: begin
                    state <= eng_idle;
                end
                default: begin
                    state <= eng_idle;
                end
            endcase
        end
    end

    // Shift register, read data and request flags
    always_ff @(posedge wb_clk) begin
        if (state == eng_idle && cmd.req) begin
            shreg     <= {cmd.code, cmd.addr, {flash_pkg::data_bits{1'b0}}};
            tx_addr_q <= cmd.tx_addr;
            no_read_q <= cmd.no_read;
        end else if (state == eng_shift) begin
            if (sck_q) begin
                // Falling edge of SCK brings the next MOSI bit
                shreg <= {shreg[$high(shreg)-1:0], 1'b0};
            end else if (in_read) begin
                // Rising edge of SCK captures MISO
                rdata_q <= {rdata_q[30:0], spi_miso};
            end
        end
    end

    assign spi_cs    = (state != eng_shift);
    assign spi_sck   = sck_q;
    assign spi_mosi  = (state == eng_shift) & shreg[$high(shreg)];
    assign cmd.ready = (state == eng_idle);
    assign cmd.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== tb/spi_flash_model.sv ====
`default_nettype none

module spi_flash_model #(
    parameter int words = 1024
) (
    input wire   spi_cs,
    input wire   spi_sck,
    input wire   spi_mosi,
    output logic spi_miso
);

    localparam int mem_bytes = 4 * words;

    logic [7:0] mem [0:mem_bytes-1];

    // Command log with one entry per CS frame
    logic [7:0]  log_op [$];
    logic [23:0] log_addr [$];
    int          log_bits [$];
    int          log_cnt;

    logic [7:0]  op;
    logic [23:0] addr;
    logic        in_frame;
    int          bit_cnt;
    int          data_idx;

    initial begin
        spi_miso = 1'b0;
        log_cnt  = 0;
        in_frame = 1'b0;
    end

    always @(negedge spi_cs) begin
        in_frame = 1'b1;
        bit_cnt  = 0;
        op       = '0;
        addr     = '0;
    end

    // MOSI is taken on rising SCK in mode 0
    always @(posedge spi_sck) begin
        if (spi_cs === 1'b0) begin
            if (bit_cnt < 8) begin
                op = {op[6:0], spi_mosi};
            end else if (bit_cnt < 32) begin
                addr = {addr[22:0], spi_mosi};
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    // Read data changes after falling SCK and each byte goes MSB first
    always @(negedge spi_sck) begin
        if (spi_cs === 1'b0 && op == 8'h03 && bit_cnt >= 32 && bit_cnt < 64) begin
            data_idx = bit_cnt - 32;
            spi_miso = mem[(int'(addr) + data_idx / 8) % mem_bytes][7 - data_idx % 8];
        end else begin
            spi_miso = 1'b0;
        end
    end

    // Log what was seen once the frame closes
    always @(posedge spi_cs) begin
        if (in_frame) begin
            log_op.push_back(op);
            log_addr.push_back(bit_cnt >= 32 ? addr : 24'h0);
            log_bits.push_back(bit_cnt);
            log_cnt  = log_cnt + 1;
            in_frame = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_ibus.sv ====
`default_nettype none

module tb_ibus;

    localparam int mem_words   = 1024;
    localparam int ack_timeout = 400;

    logic        wb_clk;
    logic        wb_rst;
    logic [31:0] wb_ibus_adr;
    logic        wb_ibus_cyc;
    wire  [31:0] wb_ibus_rdt;
    wire         wb_ibus_ack;
    wire         spi_cs;
    wire         spi_sck;
    wire         spi_mosi;
    wire         spi_miso;

    int          checks;
    int          errors;
    int          idle_fails;
    int          next_log;
    int          e0;
    int          cnt;
    int          quiet;
    int          base;
    int          i;
    logic        timed_out;
    logic [31:0] seed;
    logic [31:0] adr;

    ibus dut_i (.*);

    spi_flash_model #(.words(mem_words)) flash_i (.*);

    initial begin
        wb_clk = 1'b0;
        forever #4 wb_clk = ~wb_clk;
    end

    task automatic check_word(input string name, input flash_pkg::flash_word_t got,
                              input flash_pkg::flash_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_opcode(input string name, input flash_pkg::spi_opcode_e got,
                                input flash_pkg::spi_opcode_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input flash_pkg::flash_addr_t got,
                              input flash_pkg::flash_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%06h expected 0x%06h", name, got, exp);
        end
    endtask

    // Flash address and little-endian word that a fetch of adr must produce
    function automatic flash_pkg::flash_addr_t fetch_addr(input logic [31:0] a);
        return a[23:0] | 24'h10_0000;
    endfunction

    function automatic flash_pkg::flash_word_t model_word(input flash_pkg::flash_addr_t a);
        flash_pkg::flash_word_t w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = flash_i.mem[(int'(a) + k) % (4 * mem_words)];
        end
        return w;
    endfunction

    task automatic check_record(input int idx, input flash_pkg::spi_opcode_e op,
                                input flash_pkg::flash_addr_t a, input int bits);
        if (flash_i.log_cnt <= idx) begin
            errors++;
            $display("SPI command %0d never reached the flash model", idx);
        end else begin
            check_opcode("spi_mosi opcode", flash_pkg::spi_opcode_e'(flash_i.log_op[idx]), op);
            check_addr("spi_mosi address", flash_i.log_addr[idx], a);
            checks++;
            if (flash_i.log_bits[idx] != bits) begin
                errors++;
                $display("[FAIL] spi_cs frame bits got 0x%0h expected 0x%0h",
                         flash_i.log_bits[idx], bits);
            end
        end
    endtask

    task automatic check_fetch(input logic [31:0] a);
        check_word("wb_ibus_rdt", wb_ibus_rdt, model_word(fetch_addr(a)));
        check_record(next_log, flash_pkg::spi_read, fetch_addr(a), 64);
        next_log++;
    endtask

    // Start a fetch at the current falling edge and wait for its ack
    task automatic fetch_word(input logic [31:0] a);
        int n;
        wb_ibus_adr = a;
        wb_ibus_cyc = 1'b1;
        n = 0;
        do begin
            @(negedge wb_clk);
            n++;
        end while (!wb_ibus_ack && n < ack_timeout);
        if (!wb_ibus_ack) begin
            errors++;
            timed_out = 1'b1;
            $display("No wb_ibus_ack within %0d cycles for address 0x%08h", ack_timeout, a);
        end else begin
            check_fetch(a);
        end
    endtask

    task automatic idle_gap(input int n);
        int k;
        int e;
        for (k = 0; k < n; k++) begin
            @(negedge wb_clk);
            e = errors;
            check_word("wb_ibus_rdt", wb_ibus_rdt, '0);
            if (errors != e) begin
                idle_fails++;
            end
        end
    endtask

    initial begin
        seed       = $urandom(32'hd05b_39ca);
        checks     = 0;
        errors     = 0;
        idle_fails = 0;
        next_log   = 2;
        timed_out  = 1'b0;
        for (i = 0; i < 4 * mem_words; i++) begin
            flash_i.mem[i] = 8'($urandom);
        end
        // cyc is already up while the bridge is still in reset
        adr         = $urandom & 32'hffff_fffc;
        wb_ibus_adr = adr;
        wb_ibus_cyc = 1'b1;
        wb_rst      = 1'b1;
        repeat (16) @(negedge wb_clk);
        wb_rst = 1'b0;

        cnt   = 0;
        quiet = 0;
        while (!wb_ibus_ack && cnt < 4 * flash_pkg::recover_cycles
               && quiet < flash_pkg::recover_cycles + ack_timeout) begin
            @(negedge wb_clk);
            cnt++;
            if (flash_i.log_cnt >= 2) begin
                quiet++;
            end
        end
        check_record(0, flash_pkg::spi_reset_en, '0, 8);
        check_record(1, flash_pkg::spi_reset_req, '0, 8);
        $display("test 1 reset commands: %0d failures", errors);
        e0 = errors;
        if (!wb_ibus_ack) begin
            errors++;
            timed_out = 1'b1;
            $display("The first wb_ibus_ack never came after the flash reset");
        end else begin
            if (quiet <= flash_pkg::recover_cycles) begin
                errors++;
                $display("First wb_ibus_ack came only %0d cycles after the reset pair", quiet);
            end
            check_fetch(adr);
        end
        $display("test 2 recovery wait: %0d failures", errors - e0);
        wb_ibus_cyc = 1'b0;

        e0 = errors;
        for (i = 0; i < 200 && !timed_out; i++) begin
            idle_gap($urandom_range(1, 6));
            fetch_word($urandom & 32'hffff_fffc);
            wb_ibus_cyc = 1'b0;
        end
        $display("test 3 random reads: %0d failures", errors - e0 - idle_fails);

        // Back-to-back fetches keep cyc high across each ack
        e0   = errors;
        base = flash_i.log_cnt;
        for (cnt = 0; cnt < 40 && !timed_out; cnt++) begin
            fetch_word($urandom & 32'hffff_fffc);
        end
        wb_ibus_cyc = 1'b0;
        repeat (4) @(negedge wb_clk);
        if (!timed_out) begin
            checks++;
            // A frame still open counts as a command
            if (flash_i.log_cnt + int'(flash_i.in_frame) - base != cnt) begin
                errors++;
                $display("[FAIL] spi command count got 0x%0h expected 0x%0h",
                         flash_i.log_cnt + int'(flash_i.in_frame) - base, cnt);
            end
        end
        $display("test 4 back-to-back reads: %0d failures", errors - e0);
        $display("test 5 idle rdt zero: %0d failures", idle_fails);

        $display("checks %0d, failures %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
